// ==== tb/dual_cam_tests.txt ====
# L seed n1 n2 s1 s2 : line of n1 (camera 1) and n2 (camera 2) pixels, s1 s2 start offsets
# V vsync on both cameras, R reset for 5 cycles, E error flag expected by the end of next line
V
L 3c 8 8 0 0
L a5 8 8 0 5
L 17 8 8 6 0
L e2 8 8 0 9
V
L 58 8 7 0 3
V
E
L 91 8 8 0 0
L 4d 8 8 2 0
R
L 6b 8 8 0 4
V
L c3 8 8 1 1

// ==== dual_cam_pipe.f ====
logic/video_pkg.sv
logic/pix_stream_if.sv
logic/fifo_read_if.sv
logic/cam_pixel_packer.sv
logic/line_fifo.sv
logic/pixel_combine.sv
logic/dual_cam_pipe.sv
tb/dual_cam_pipe_tb.sv

// ==== tb/dual_cam_pipe_tb.sv ====
`timescale 1ns/1ps

module dual_cam_pipe_tb;

    localparam int LINE_PIXELS = 8;
    localparam int HS_AFTER    = 4;
    localparam int HS_HOLD     = 3;
    localparam int GAP         = 10;    // Idle cycles after a line leave room for the sync pulse
    localparam int REC_CYCLES  = 64;    // Upper bound of cycles one record can take

    logic        clk;
    logic        rst;
    logic        cam1_vsync;
    logic        cam1_href;
    logic [7:0]  cam1_data;
    logic        cam2_vsync;
    logic        cam2_href;
    logic [7:0]  cam2_data;
    logic        de;
    logic [7:0]  r;
    logic [7:0]  g;
    logic [7:0]  b;
    logic [15:0] pixel_2;
    logic        hsync;
    logic        error;

    // Expected pixel entry {push cycle, high byte, low byte, line_last}
    logic [48:0] q1[$];
    logic [48:0] q2[$];
    logic        phase[2];
    logic [7:0]  hi[2];
    int          cnt[2];
    int          cyc;
    int          last_le;          // Cycle of the last de that closed a line
    logic        exp_err;
    logic        err_due;
    int          limit_ns = 0;

    dual_cam_pipe dut0 (
        .clk       (clk       ),
        .rst       (rst       ),
        .cam1_vsync(cam1_vsync),
        .cam1_href (cam1_href ),
        .cam1_data (cam1_data ),
        .cam2_vsync(cam2_vsync),
        .cam2_href (cam2_href ),
        .cam2_data (cam2_data ),
        .de        (de        ),
        .r         (r         ),
        .g         (g         ),
        .b         (b         ),
        .pixel_2   (pixel_2   ),
        .hsync     (hsync     ),
        .error     (error     )
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [15:0] exp,
                                   input logic [15:0] act);
        $display("error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic clear_model();
        q1.delete();
        q2.delete();
        phase[0] = 1'b0;
        phase[1] = 1'b0;
        cnt[0]   = 0;
        cnt[1]   = 0;
        exp_err  = 1'b0;
        last_le  = -1000;
    endtask

    // ----------------------------------------------------------------------
    // Reference model of the packers and the pair checker
    // ----------------------------------------------------------------------
    task automatic model_byte(input int cam, input logic vs, input logic hs, input logic [7:0] d);
        logic [48:0] w;
        if (vs) begin
            phase[cam] = 1'b0;
            cnt[cam]   = 0;
        end else if (hs) begin
            if (phase[cam]) begin
                w = {32'(cyc), hi[cam], d, cnt[cam] == LINE_PIXELS - 1};
                cnt[cam] = (cnt[cam] == LINE_PIXELS - 1) ? 0 : cnt[cam] + 1;
                if (cam == 0)
                    q1.push_back(w);
                else
                    q2.push_back(w);
            end else begin
                hi[cam] = d;               // First byte of a pair is the high byte
            end
            phase[cam] = !phase[cam];
        end
    endtask

    task automatic check_outputs();
        logic [48:0] w1;
        logic [48:0] w2;
        logic        exp_de;
        logic        exp_hs;
        exp_de = 1'b0;
        if (q1.size() > 0 && q2.size() > 0) begin
            // A pair shows up three cycles after the later second byte
            exp_de = (cyc >= q1[0][48:17] + 3) && (cyc >= q2[0][48:17] + 3);
        end
        assert (de === exp_de) else report_mismatch("de", exp_de, de);
        if (exp_de) begin
            w1 = q1.pop_front();
            w2 = q2.pop_front();
            assert (r === {w1[16:12], 3'b000})
                else report_mismatch("r", {w1[16:12], 3'b000}, r);
            assert (g === {w1[11:6], 2'b00})
                else report_mismatch("g", {w1[11:6], 2'b00}, g);
            assert (b === {w1[5:1], 3'b000})
                else report_mismatch("b", {w1[5:1], 3'b000}, b);
            assert (pixel_2 === w2[16:1]) else report_mismatch("pixel_2", w2[16:1], pixel_2);
            if (w1[0] != w2[0])
                exp_err = 1'b1;
            if (w1[0] && w2[0])
                last_le = cyc;
        end
        exp_hs = (cyc - last_le >= HS_AFTER) && (cyc - last_le < HS_AFTER + HS_HOLD);
        assert (hsync === exp_hs) else report_mismatch("hsync", exp_hs, hsync);
        assert (error === exp_err) else report_mismatch("error", exp_err, error);
    endtask

    // One clock cycle where outputs are checked before the new inputs go out
    task automatic step(input logic rst_val, input logic v1, input logic h1,
                        input logic [7:0] d1, input logic v2, input logic h2,
                        input logic [7:0] d2);
        @(posedge clk);
        #1;
        cyc++;
        check_outputs();
        rst        = rst_val;
        cam1_vsync = v1;
        cam1_href  = h1;
        cam1_data  = d1;
        cam2_vsync = v2;
        cam2_href  = h2;
        cam2_data  = d2;
        if (rst_val)
            clear_model();
        model_byte(0, v1, h1, d1);
        model_byte(1, v2, h2, d2);
    endtask

    task automatic send_line(input logic [7:0] seed, input int n1, input int n2,
                             input int s1, input int s2);
        int         len;
        int         k;
        logic       h1;
        logic       h2;
        logic [7:0] d1;
        logic [7:0] d2;
        len = ((s1 + 2 * n1) > (s2 + 2 * n2) ? s1 + 2 * n1 : s2 + 2 * n2) + GAP;
        for (k = 0; k < len; k++) begin
            h1 = (k >= s1) && (k < s1 + 2 * n1);
            h2 = (k >= s2) && (k < s2 + 2 * n2);
            d1 = h1 ? seed + 8'(k * 29) : 8'h00;
            d2 = h2 ? ~seed + 8'(k * 53) : 8'h00;
            step(1'b0, 1'b0, h1, d1, 1'b0, h2, d2);
        end
        if (err_due) begin
            assert (error === 1'b1) else report_mismatch("error", 1'b1, error);
            err_due = 1'b0;
        end
    endtask

    initial begin : watchdog
        wait (limit_ns > 0);
        #(limit_ns);
        $display("timeout: the test records did not finish within %0d ns", limit_ns);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        string      line;
        string      recs[$];
        int         fd;
        int         n;
        logic [7:0] seed;
        int         n1;
        int         n2;
        int         s1;
        int         s2;
        rst        = 1'b1;
        cam1_vsync = 1'b0;
        cam1_href  = 1'b0;
        cam1_data  = 8'h00;
        cam2_vsync = 1'b0;
        cam2_href  = 1'b0;
        cam2_data  = 8'h00;
        cyc        = 0;
        err_due    = 1'b0;
        clear_model();

        fd = $fopen("tb/dual_cam_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open tb/dual_cam_tests.txt");
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.getc(0) != "#" && line.getc(0) != "\n")
                recs.push_back(line);
        end
        $fclose(fd);
        limit_ns = (recs.size() * REC_CYCLES + 200) * 4;

        repeat (4) step(1'b1, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00);   // rst high since time 0
        foreach (recs[i]) begin
            if (recs[i].getc(0) == "R") begin
                repeat (5) step(1'b1, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00);
            end else if (recs[i].getc(0) == "V") begin
                repeat (2) step(1'b0, 1'b1, 1'b0, 8'h00, 1'b1, 1'b0, 8'h00);
                repeat (2) step(1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00);
            end else if (recs[i].getc(0) == "E") begin
                err_due = 1'b1;
            end else if (recs[i].getc(0) == "L") begin
                if ($sscanf(recs[i], "L %h %d %d %d %d", seed, n1, n2, s1, s2) != 5)
                    abort_run($sformatf("malformed line record: %s", recs[i]));
                send_line(seed, n1, n2, s1, s2);
            end else begin
                abort_run($sformatf("unknown record in the test file: %s", recs[i]));
            end
        end
        repeat (GAP) step(1'b0, 1'b0, 1'b0, 8'h00, 1'b0, 1'b0, 8'h00);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule : dual_cam_pipe_tb

// ==== logic/dual_cam_pipe.sv ====
`timescale 1ns/1ps

module dual_cam_pipe import video_pkg::*; #(
    parameter int LINE_PIXELS = 8,
    parameter int FIFO_DEPTH  = 16,
    parameter int HS_AFTER    = 4,
    parameter int HS_HOLD     = 3
) (
    input  logic        clk,
    input  logic        rst,

    input  logic        cam1_vsync,
    input  logic        cam1_href,
    input  logic [7:0]  cam1_data,

    input  logic        cam2_vsync,
    input  logic        cam2_href,
    input  logic [7:0]  cam2_data,

    output logic        de,
    output logic [7:0]  r,
    output logic [7:0]  g,
    output logic [7:0]  b,
    output rgb565_t     pixel_2,
    output logic        hsync,
    output logic        error
);

    pix_stream_if cam1_stream ();
    pix_stream_if cam2_stream ();
    fifo_read_if  cam1_rd ();
    fifo_read_if  cam2_rd ();

    // ----------------------------------------------------------------------
    // Camera 1 path
    // ----------------------------------------------------------------------
    cam_pixel_packer #(.LINE_PIXELS(LINE_PIXELS)) u_cam1_packer (
        .clk  (clk        ),
        .rst  (rst        ),
        .vsync(cam1_vsync ),
        .href (cam1_href  ),
        .data (cam1_data  ),
        .out  (cam1_stream)
    );

    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(pix_word_t)) u_cam1_fifo (
        .clk(clk        ),
        .rst(rst        ),
        .wr (cam1_stream),
        .rd (cam1_rd    )
    );

    // ----------------------------------------------------------------------
    // Camera 2 path
    // ----------------------------------------------------------------------
    cam_pixel_packer #(.LINE_PIXELS(LINE_PIXELS)) u_cam2_packer (
        .clk  (clk        ),
        .rst  (rst        ),
        .vsync(cam2_vsync ),
        .href (cam2_href  ),
        .data (cam2_data  ),
        .out  (cam2_stream)
    );

    line_fifo #(.FIFO_DEPTH(FIFO_DEPTH), .payload_t(pix_word_t)) u_cam2_fifo (
        .clk(clk        ),
        .rst(rst        ),
        .wr (cam2_stream),
        .rd (cam2_rd    )
    );

    pixel_combine #(.HS_AFTER(HS_AFTER), .HS_HOLD(HS_HOLD)) u_pixel_combine (
        .clk    (clk    ),
        .rst    (rst    ),
        .rd_1   (cam1_rd),
        .rd_2   (cam2_rd),
        .de     (de     ),
        .r      (r      ),
        .g      (g      ),
        .b      (b      ),
        .pixel_2(pixel_2),
        .hsync  (hsync  ),
        .error  (error  )
    );

endmodule : dual_cam_pipe

// ==== logic/pixel_combine.sv ====
`timescale 1ns/1ps

module pixel_combine import video_pkg::*; #(
    parameter int HS_AFTER = 4,
    parameter int HS_HOLD  = 3
) (
    input  logic        clk,
    input  logic        rst,
    fifo_read_if.dst    rd_1,
    fifo_read_if.dst    rd_2,
    output logic        de,
    output logic [7:0]  r,
    output logic [7:0]  g,
    output logic [7:0]  b,
    output rgb565_t     pixel_2,
    output logic        hsync,
    output logic        error
);

    localparam int HS_TOTAL = HS_AFTER + HS_HOLD;
    localparam int HS_W     = $clog2(HS_TOTAL + 1);

    logic            pop;
    logic            line_end;
    logic            mismatch;
    logic [HS_W-1:0] hs_cnt;

    // Both sides are popped together so the pair stays aligned
    assign pop      = !rd_1.empty && !rd_2.empty;
    assign rd_1.pop = pop;
    assign rd_2.pop = pop;

    assign line_end = pop && rd_1.data.line_last && rd_2.data.line_last;
    assign mismatch = pop && (rd_1.data.line_last != rd_2.data.line_last);

    // ----------------------------------------------------------------------
    // Display enable, sync counter and sticky error
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            de     <= 1'b0;
            hs_cnt <= '0;
            error  <= 1'b0;
        end else begin
            de <= pop;
            if (line_end) begin
                hs_cnt <= HS_W'(HS_TOTAL);       // Counts down through delay then pulse
            end else if (hs_cnt != '0) begin
                hs_cnt <= hs_cnt - 1'b1;
            end
            if (mismatch || rd_1.overflow || rd_2.overflow) begin
                error <= 1'b1;
            end
        end
    end

    // Pulse covers the last HS_HOLD counts of the window
    assign hsync = (hs_cnt != '0) && (hs_cnt <= HS_W'(HS_HOLD));

    always_ff @(posedge clk) begin
        if (pop) begin
            r       <= expand_r(rd_1.data.pixel.red);
            g       <= expand_g(rd_1.data.pixel.green);
            b       <= expand_b(rd_1.data.pixel.blue);
            pixel_2 <= rd_2.data.pixel;          // Kept raw for the stereo path
        end
    end

    // Cameras must leave enough blanking for the sync pulse
    assert property (@(posedge clk) disable iff (rst) !(hsync && de));

endmodule : pixel_combine

// ==== logic/line_fifo.sv ====
`timescale 1ns/1ps

module line_fifo import video_pkg::*; #(
    parameter int  FIFO_DEPTH = 16,
    parameter type payload_t  = pix_word_t
) (
    input  logic        clk,
    input  logic        rst,
    pix_stream_if.dst   wr,
    fifo_read_if.src    rd
);

    localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    payload_t      mem [FIFO_DEPTH];
    payload_t      wr_word;
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          full;
    logic          do_wr;
    logic          do_rd;
    logic          overflow_q;

    assign wr_word = payload_t'({wr.pixel, wr.line_last});
    assign full    = (count == (AW+1)'(FIFO_DEPTH));
    assign do_wr   = wr.valid && !full;               // Writes into a full FIFO are lost
    assign do_rd   = rd.pop && !rd.empty;

    assign rd.empty    = (count == '0);
    assign rd.data     = mem[rd_ptr];                 // Head word falls through
    assign rd.overflow = overflow_q;
    assign wr.overflow = overflow_q;

    // ----------------------------------------------------------------------
    // Pointers, fill level and overflow flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_q <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;              // Wraps since depth is a power of two
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (wr.valid && full) begin
                overflow_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    // The consumer must look at empty before popping
    assert property (@(posedge clk) disable iff (rst) rd.pop |-> !rd.empty);

    assert property (@(posedge clk) disable iff (rst) count <= (AW+1)'(FIFO_DEPTH));

endmodule : line_fifo

// ==== logic/cam_pixel_packer.sv ====
`timescale 1ns/1ps

module cam_pixel_packer import video_pkg::*; #(
    parameter int LINE_PIXELS = 8
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         vsync,
    input  logic         href,
    input  logic [7:0]   data,
    pix_stream_if.src    out
);

    localparam int CNT_W = (LINE_PIXELS > 1) ? $clog2(LINE_PIXELS) : 1;

    logic [7:0]       hi_byte;
    logic             phase;      // High once the first byte of a pair is held
    logic [CNT_W-1:0] pix_cnt;
    logic             sof_pend;
    logic             take_lo;
    logic             at_last;

    assign take_lo = href && phase && !vsync;
    assign at_last = (pix_cnt == CNT_W'(LINE_PIXELS - 1));

    // ----------------------------------------------------------------------
    // Byte phase, pixel counter and strobes
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            phase         <= 1'b0;
            pix_cnt       <= '0;
            sof_pend      <= 1'b0;
            out.valid     <= 1'b0;
            out.line_last <= 1'b0;
            out.sof       <= 1'b0;
        end else begin
            out.valid <= 1'b0;
            out.sof   <= 1'b0;
            if (vsync) begin
                phase    <= 1'b0;          // A new frame restarts pairing
                pix_cnt  <= '0;
                sof_pend <= 1'b1;
            end else if (href) begin
                phase <= !phase;
                if (phase) begin
                    out.valid     <= 1'b1;
                    out.line_last <= at_last;
                    out.sof       <= sof_pend;
                    sof_pend      <= 1'b0;
                    pix_cnt       <= at_last ? '0 : pix_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (href && !phase && !vsync) begin
            hi_byte <= data;                      // First byte is the high byte
        end
        if (take_lo) begin
            out.pixel <= rgb565_t'({hi_byte, data});
        end
    end

    // Pixels need two bytes, so strobes can never be back to back
    assert property (@(posedge clk) disable iff (rst) out.valid |=> !out.valid);

endmodule : cam_pixel_packer

// ==== logic/fifo_read_if.sv ====
`timescale 1ns/1ps

interface fifo_read_if import video_pkg::*; ();

    logic      empty;
    logic      pop;        // Only legal while empty is low
    pix_word_t data;       // Head word, valid whenever empty is low
    logic      overflow;

    // FIFO side
    modport src (
        output empty,
        output data,
        output overflow,
        input  pop
    );

    // Consumer side
    modport dst (
        input  empty,
        input  data,
        input  overflow,
        output pop
    );

endinterface : fifo_read_if

// ==== logic/pix_stream_if.sv ====
`timescale 1ns/1ps

interface pix_stream_if import video_pkg::*; ();

    logic    valid;        // One pixel per high cycle without back-pressure
    rgb565_t pixel;
    logic    line_last;    // Last pixel of the line
    logic    sof;          // First pixel after vsync
    logic    overflow;     // Sticky FIFO overflow seen back on the source side

    modport src (
        output valid,
        output pixel,
        output line_last,
        output sof,
        input  overflow
    );

    modport dst (
        input  valid,
        input  pixel,
        input  line_last,
        input  sof,
        output overflow
    );

endinterface : pix_stream_if

// ==== logic/video_pkg.sv ====
package video_pkg;

    // ----------------------------------------------------------------------
    // Channel widths of the RGB565 pixel and of the display side
    // ----------------------------------------------------------------------
    localparam int CH_BITS = 8;
    localparam int R_BITS  = 5;
    localparam int G_BITS  = 6;
    localparam int B_BITS  = 5;

    localparam int R_PAD = CH_BITS - R_BITS;    // Zero bits appended to red
    localparam int G_PAD = CH_BITS - G_BITS;    // Zero bits appended to green
    localparam int B_PAD = CH_BITS - B_BITS;    // Zero bits appended to blue

    typedef struct packed {
        logic [R_BITS-1:0] red;
        logic [G_BITS-1:0] green;
        logic [B_BITS-1:0] blue;
    } rgb565_t;

    // One FIFO entry holds a pixel and its end-of-line mark
    typedef struct packed {
        rgb565_t pixel;
        logic    line_last;
    } pix_word_t;

    function automatic logic [CH_BITS-1:0] expand_r(input logic [R_BITS-1:0] c);
        return {c, {R_PAD{1'b0}}};
    endfunction

    function automatic logic [CH_BITS-1:0] expand_g(input logic [G_BITS-1:0] c);
        return {c, {G_PAD{1'b0}}};
    endfunction

    function automatic logic [CH_BITS-1:0] expand_b(input logic [B_BITS-1:0] c);
        return {c, {B_PAD{1'b0}}};
    endfunction

endpackage : video_pkg
